//--- source/fpu_mem_pkg.sv
`default_nettype none

package fpu_mem_pkg;

	// dram line
	localparam int LINE_BYTES = 64;
	localparam int LINE_BITS = LINE_BYTES * 8;

	// buffer write word
	localparam int WORD_BYTES = 8;

	// operand buffer geometry
	localparam int BUF_ROW_BYTES = 512;
	localparam int BUF_ROWS = 8;
	localparam int BUF_BYTES = BUF_ROW_BYTES * BUF_ROWS;

	localparam int BUF_AW = 12; // byte address
	localparam int BUF_WAW = 9; // 64-bit word address

	localparam int LINE_IDX_W = 3; // line within a row
	localparam int ROW_IDX_W = 3;

endpackage

`default_nettype wire

//--- source/fpu_ctrl_pkg.sv
`default_nettype none

package fpu_ctrl_pkg;

	typedef enum logic [1:0] {
		CMD_STORE      = 2'd0, // buffer to dram
		CMD_LOAD       = 2'd1, // dram to buffer
		CMD_STORE_LOAD = 2'd2
	} cmd_e;

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_ST_ROW,    // first pack of a store
		ST_ST_PACK,
		ST_ST_SEND,   // waiting on the dram holding register
		ST_LD_ROW,    // load request goes out
		ST_LD_REQ,
		ST_LD_WAIT,
		ST_LD_UNPACK,
		ST_DONE
	} xfer_state_e;

	// apb register map
	localparam logic [7:0] REG_CTRL    = 8'h00;
	localparam logic [7:0] REG_STATUS  = 8'h04;
	localparam logic [7:0] REG_WR_ADDR = 8'h08;
	localparam logic [7:0] REG_RD_ADDR = 8'h0C;
	localparam logic [7:0] REG_WIDTH   = 8'h10;
	localparam logic [7:0] REG_HEIGHT  = 8'h14;
	localparam logic [7:0] REG_STRIDE  = 8'h18;

endpackage

`default_nettype wire

//--- source/fpu_apb_regs.sv
`timescale 1ns/100ps
`default_nettype none

module fpu_apb_regs import fpu_mem_pkg::*, fpu_ctrl_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [7:0]  paddr,
	input  logic [31:0] pwdata,
	input  logic        busy,
	input  logic        done_pulse,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	output logic        start,
	output cmd_e        cmd,
	output logic [31:0] wr_addr,
	output logic [31:0] rd_addr,
	output logic [9:0]  width,
	output logic [3:0]  height,
	output logic [31:0] stride
);

	logic wr_acc;
	logic go;
	logic geom_ok;
	logic accept;
	logic done_q;
	logic err_q;

	assign wr_acc = psel && penable && pwrite;
	assign go = wr_acc && (paddr == REG_CTRL) && pwdata[0];

	// whole lines only, at most one buffer row wide and one buffer tall
	assign geom_ok = (width != '0) && (width[$clog2(LINE_BYTES)-1:0] == '0) &&
		(width <= 10'(BUF_ROW_BYTES)) && (height != '0) && (height <= 4'(BUF_ROWS));

	assign accept = go && !busy && geom_ok;
	assign pslverr = go && !accept;
	assign pready = 1'b1; // no wait states

	always_comb begin
		case (paddr)
			REG_CTRL:    prdata = {29'd0, cmd, 1'b0};
			REG_STATUS:  prdata = {29'd0, err_q, done_q, busy};
			REG_WR_ADDR: prdata = wr_addr;
			REG_RD_ADDR: prdata = rd_addr;
			REG_WIDTH:   prdata = {22'd0, width};
			REG_HEIGHT:  prdata = {28'd0, height};
			REG_STRIDE:  prdata = stride;
			default:     prdata = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			start <= 1'b0;
			cmd <= CMD_STORE;
			wr_addr <= '0;
			rd_addr <= '0;
			width <= '0;
			height <= '0;
			stride <= '0;
			done_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			start <= accept; // single cycle
			if (accept)
				cmd <= cmd_e'(pwdata[2:1]);
			if (wr_acc) begin
				case (paddr)
					REG_WR_ADDR: wr_addr <= pwdata;
					REG_RD_ADDR: rd_addr <= pwdata;
					REG_WIDTH:   width <= pwdata[9:0];
					REG_HEIGHT:  height <= pwdata[3:0];
					REG_STRIDE:  stride <= pwdata;
					default: ;
				endcase
			end
			if (accept)
				done_q <= 1'b0;
			else if (done_pulse)
				done_q <= 1'b1;
			if (accept)
				err_q <= 1'b0;
			else if (pslverr)
				err_q <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- source/fpu_req_controller.sv
`timescale 1ns/100ps
`default_nettype none

module fpu_req_controller import fpu_mem_pkg::*, fpu_ctrl_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start,
	input  cmd_e                 cmd,
	input  logic [31:0]          wr_addr,
	input  logic [31:0]          rd_addr,
	input  logic [9:0]           width,
	input  logic [3:0]           height,
	input  logic [31:0]          stride,
	input  logic                 pack_done,
	input  logic [LINE_BITS-1:0] pack_line,
	input  logic                 unpack_busy,
	input  logic                 dram_ready,
	input  logic                 dram_rvalid,
	input  logic [LINE_BITS-1:0] dram_rdata,
	output logic                 busy,
	output logic                 done_pulse,
	output logic                 pack_start,
	output logic [BUF_AW-1:0]    pack_base,
	output logic                 unpack_start,
	output logic [LINE_BITS-1:0] unpack_line,
	output logic [BUF_WAW-1:0]   unpack_base,
	output logic                 dram_valid,
	output logic                 dram_we,
	output logic [31:0]          dram_addr,
	output logic [LINE_BITS-1:0] dram_wdata
);

	xfer_state_e state, state_nx;

	cmd_e                  cmd_q;
	logic [LINE_IDX_W-1:0] lines_m1;
	logic [ROW_IDX_W-1:0]  rows_m1;
	logic [31:0]           stride_q;
	logic [31:0]           rd_base;
	logic [31:0]           row_addr; // dram address of the current row
	logic [LINE_IDX_W-1:0] line;
	logic [ROW_IDX_W-1:0]  row;
	logic [LINE_IDX_W-1:0] nxt_line;
	logic [ROW_IDX_W-1:0]  nxt_row;
	logic [31:0]           line_off;
	logic                  line_wrap;
	logic                  last_line;
	logic                  last_held; // final store line sits in the holder
	logic                  xfer;
	logic                  holder_free;
	logic                  take_start;
	logic                  hold_load;
	logic                  adv;
	logic                  st_leave;

	assign line_wrap = (line == lines_m1);
	assign last_line = line_wrap && (row == rows_m1);
	assign nxt_line = line_wrap ? '0 : line + 1'b1;
	assign nxt_row = line_wrap ? row + 1'b1 : row;
	assign line_off = {{(32 - LINE_IDX_W - 6){1'b0}}, line, 6'd0};

	assign xfer = dram_valid && dram_ready;
	assign holder_free = !dram_valid || dram_ready;
	assign take_start = start && (state == ST_IDLE || state == ST_DONE);
	assign st_leave = (state == ST_ST_SEND) && last_held && xfer;

	// packer is restarted with the next line's base when advancing
	assign pack_base = adv ? {nxt_row, nxt_line, 6'd0} : {row, line, 6'd0};
	assign unpack_base = {row, line, 3'd0};
	assign unpack_line = dram_rdata;

	assign busy = (state != ST_IDLE && state != ST_DONE) || start;

	always_comb begin
		state_nx = state;
		pack_start = 1'b0;
		unpack_start = 1'b0;
		hold_load = 1'b0;
		adv = 1'b0;
		done_pulse = 1'b0;
		case (state)
			ST_IDLE, ST_DONE: begin
				if (start)
					state_nx = (cmd == CMD_LOAD) ? ST_LD_ROW : ST_ST_ROW;
				else
					state_nx = ST_IDLE;
			end
			ST_ST_ROW: begin
				pack_start = 1'b1;
				state_nx = ST_ST_PACK;
			end
			ST_ST_PACK: begin
				if (pack_done) begin
					if (holder_free) begin
						hold_load = 1'b1;
						if (last_line) begin
							state_nx = ST_ST_SEND;
						end else begin
							adv = 1'b1;
							pack_start = 1'b1;
						end
					end else begin
						state_nx = ST_ST_SEND; // line parked in the packer
					end
				end
			end
			ST_ST_SEND: begin
				if (last_held) begin
					if (xfer) begin
						if (cmd_q == CMD_STORE_LOAD) begin
							state_nx = ST_LD_ROW;
						end else begin
							done_pulse = 1'b1;
							state_nx = ST_DONE;
						end
					end
				end else if (holder_free) begin
					hold_load = 1'b1;
					if (!last_line) begin
						adv = 1'b1;
						pack_start = 1'b1;
						state_nx = ST_ST_PACK;
					end
				end
			end
			ST_LD_ROW: state_nx = ST_LD_REQ;
			ST_LD_REQ: begin
				if (dram_ready)
					state_nx = ST_LD_WAIT;
			end
			ST_LD_WAIT: begin
				if (dram_rvalid) begin
					unpack_start = 1'b1;
					state_nx = ST_LD_UNPACK;
				end
			end
			ST_LD_UNPACK: begin
				if (!unpack_busy) begin // last word written this cycle
					if (last_line) begin
						done_pulse = 1'b1;
						state_nx = ST_DONE;
					end else begin
						adv = 1'b1;
						state_nx = ST_LD_ROW;
					end
				end
			end
			default: state_nx = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			cmd_q <= CMD_STORE;
			lines_m1 <= '0;
			rows_m1 <= '0;
			stride_q <= '0;
			rd_base <= '0;
			row_addr <= '0;
			line <= '0;
			row <= '0;
			last_held <= 1'b0;
			dram_valid <= 1'b0;
			dram_we <= 1'b0;
			dram_addr <= '0;
		end else begin
			state <= state_nx;
			if (take_start) begin
				cmd_q <= cmd;
				lines_m1 <= LINE_IDX_W'(width[9:6] - 4'd1);
				rows_m1 <= ROW_IDX_W'(height - 4'd1);
				stride_q <= stride;
				rd_base <= rd_addr;
				row_addr <= (cmd == CMD_LOAD) ? rd_addr : wr_addr;
				line <= '0;
				row <= '0;
			end else if (st_leave) begin
				row_addr <= rd_base; // load half of store-then-load
				line <= '0;
				row <= '0;
			end else if (adv) begin
				line <= nxt_line;
				row <= nxt_row;
				if (line_wrap)
					row_addr <= row_addr + stride_q;
			end

			if (hold_load && last_line)
				last_held <= 1'b1;
			else if (st_leave)
				last_held <= 1'b0;

			if (xfer)
				dram_valid <= 1'b0;
			if (hold_load) begin
				dram_valid <= 1'b1;
				dram_we <= 1'b1;
				dram_addr <= row_addr + line_off;
			end else if (state == ST_LD_ROW) begin
				dram_valid <= 1'b1;
				dram_we <= 1'b0;
				dram_addr <= row_addr + line_off;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (hold_load)
			dram_wdata <= pack_line;
	end

	a_dram_hold: assert property (@(posedge clk) disable iff (!rst_n)
		dram_valid && !dram_ready |=> dram_valid && $stable(dram_we) &&
		$stable(dram_addr) && $stable(dram_wdata));

endmodule

`default_nettype wire

//--- source/line_packer.sv
`timescale 1ns/100ps
`default_nettype none

module line_packer import fpu_mem_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 pack_start,
	input  logic [BUF_AW-1:0]    pack_base,
	input  logic [7:0]           rd_byte,
	output logic [BUF_AW-1:0]    rd_addr,
	output logic                 pack_done,
	output logic [LINE_BITS-1:0] pack_line
);

	logic                          active; // bytes returning from the buffer
	logic [$clog2(LINE_BYTES)-1:0] cnt;
	logic [BUF_AW-1:0]             rd_ptr;

	// first read goes out with the start strobe
	assign rd_addr = pack_start ? pack_base : rd_ptr;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			cnt <= '0;
			rd_ptr <= '0;
			pack_done <= 1'b0;
		end else begin
			pack_done <= 1'b0;
			if (pack_start) begin
				active <= 1'b1;
				cnt <= '0;
				rd_ptr <= pack_base + 1'b1;
			end else if (active) begin
				rd_ptr <= rd_ptr + 1'b1;
				cnt <= cnt + 1'b1;
				if (cnt == 6'(LINE_BYTES - 1)) begin
					active <= 1'b0;
					pack_done <= 1'b1;
				end
			end
		end
	end

	// first byte ends up on top
	always_ff @(posedge clk) begin
		if (active)
			pack_line <= {pack_line[LINE_BITS-9:0], rd_byte};
	end

	a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
		pack_start |-> !active);

endmodule

`default_nettype wire

//--- source/line_unpacker.sv
`timescale 1ns/100ps
`default_nettype none

module line_unpacker import fpu_mem_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 unpack_start,
	input  logic [LINE_BITS-1:0] unpack_line,
	input  logic [BUF_WAW-1:0]   unpack_base,
	output logic                 wr_en,
	output logic [BUF_WAW-1:0]   wr_word_addr,
	output logic [63:0]          wr_word,
	output logic                 unpack_busy
);

	localparam int WORD_BITS = WORD_BYTES * 8;

	logic                 active;
	logic [2:0]           cnt;
	logic [LINE_BITS-1:0] line_q;
	logic [BUF_WAW-1:0]   base_q;

	assign wr_en = active;
	assign wr_word = line_q[LINE_BITS-1 -: WORD_BITS]; // top word first
	assign wr_word_addr = base_q + BUF_WAW'(cnt);
	assign unpack_busy = active && (cnt != 3'd7); // more words after this one

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			cnt <= '0;
		end else if (unpack_start) begin
			active <= 1'b1;
			cnt <= '0;
		end else if (active) begin
			cnt <= cnt + 1'b1;
			if (cnt == 3'd7)
				active <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (unpack_start) begin
			line_q <= unpack_line;
			base_q <= unpack_base;
		end else if (active) begin
			line_q <= line_q << WORD_BITS;
		end
	end

endmodule

`default_nettype wire

//--- source/fpu_line_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module fpu_line_buffer import fpu_mem_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               busy,
	input  logic [BUF_AW-1:0]  rd_addr,
	input  logic               wr_en,
	input  logic [BUF_WAW-1:0] wr_word_addr,
	input  logic [63:0]        wr_word,
	input  logic [BUF_AW-1:0]  host_addr,
	input  logic               host_we,
	input  logic [7:0]         host_wdata,
	output logic [7:0]         rd_byte,
	output logic [7:0]         host_rdata
);

	logic [BUF_AW-1:0]  raddr;
	logic [BUF_WAW-1:0] widx;
	logic [7:0]         lane_q [WORD_BYTES];
	logic [2:0]         sel_q; // lane of the pending read

	// engine owns the ports while a command runs
	assign raddr = busy ? rd_addr : host_addr;
	assign widx = busy ? wr_word_addr : host_addr[BUF_AW-1:3];

	for (genvar j = 0; j < WORD_BYTES; j++) begin : g_lane
		logic [7:0] mem [BUF_BYTES / WORD_BYTES];
		logic       we;
		logic [7:0] wdata;

		assign we = busy ? wr_en : (host_we && host_addr[2:0] == 3'(j));
		assign wdata = busy ? wr_word[(WORD_BYTES - j) * 8 - 1 -: 8] : host_wdata;

		always_ff @(posedge clk) begin
			if (we)
				mem[widx] <= wdata;
			lane_q[j] <= mem[raddr[BUF_AW-1:3]];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			sel_q <= '0;
		else
			sel_q <= raddr[2:0];
	end

	assign rd_byte = lane_q[sel_q];
	assign host_rdata = lane_q[sel_q];

endmodule

`default_nettype wire

//--- source/fpu_dma_top.sv
`timescale 1ns/100ps
`default_nettype none

module fpu_dma_top import fpu_mem_pkg::*, fpu_ctrl_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  logic [7:0]           paddr,
	input  logic [31:0]          pwdata,
	output logic [31:0]          prdata,
	output logic                 pready,
	output logic                 pslverr,
	output logic                 dram_valid,
	output logic                 dram_we,
	output logic [31:0]          dram_addr,
	output logic [LINE_BITS-1:0] dram_wdata,
	input  logic                 dram_ready,
	input  logic                 dram_rvalid,
	input  logic [LINE_BITS-1:0] dram_rdata,
	input  logic [BUF_AW-1:0]    host_addr,
	input  logic                 host_we,
	input  logic [7:0]           host_wdata,
	output logic [7:0]           host_rdata
);

	logic                 start;
	cmd_e                 cmd;
	logic [31:0]          cfg_wr_addr;
	logic [31:0]          cfg_rd_addr;
	logic [9:0]           width;
	logic [3:0]           height;
	logic [31:0]          stride;
	logic                 busy;
	logic                 done_pulse;
	logic                 pack_start;
	logic [BUF_AW-1:0]    pack_base;
	logic                 pack_done;
	logic [LINE_BITS-1:0] pack_line;
	logic                 unpack_start;
	logic [LINE_BITS-1:0] unpack_line;
	logic [BUF_WAW-1:0]   unpack_base;
	logic                 unpack_busy;
	logic [BUF_AW-1:0]    buf_rd_addr;
	logic [7:0]           rd_byte;
	logic                 wr_en;
	logic [BUF_WAW-1:0]   wr_word_addr;
	logic [63:0]          wr_word;

	fpu_apb_regs u_apb_regs (
		.clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
		.busy, .done_pulse, .prdata, .pready, .pslverr, .start, .cmd,
		.wr_addr(cfg_wr_addr), .rd_addr(cfg_rd_addr), .width, .height, .stride
	);

	fpu_req_controller u_req_ctrl (
		.clk, .rst_n, .start, .cmd, .wr_addr(cfg_wr_addr), .rd_addr(cfg_rd_addr),
		.width, .height, .stride, .pack_done, .pack_line, .unpack_busy,
		.dram_ready, .dram_rvalid, .dram_rdata, .busy, .done_pulse,
		.pack_start, .pack_base, .unpack_start, .unpack_line, .unpack_base,
		.dram_valid, .dram_we, .dram_addr, .dram_wdata
	);

	line_packer u_packer (
		.clk, .rst_n, .pack_start, .pack_base, .rd_byte,
		.rd_addr(buf_rd_addr), .pack_done, .pack_line
	);

	line_unpacker u_unpacker (
		.clk, .rst_n, .unpack_start, .unpack_line, .unpack_base,
		.wr_en, .wr_word_addr, .wr_word, .unpack_busy
	);

	fpu_line_buffer u_buffer (
		.clk, .rst_n, .busy, .rd_addr(buf_rd_addr), .wr_en, .wr_word_addr, .wr_word,
		.host_addr, .host_we, .host_wdata, .rd_byte, .host_rdata
	);

endmodule

`default_nettype wire

//--- tb/tb_fpu_dma.sv
`timescale 1ns/100ps
`default_nettype none

module tb_fpu_dma import fpu_mem_pkg::*, fpu_ctrl_pkg::*;;

	localparam logic [31:0] SEED = 32'hbb41_5cb4;
	localparam int TOTAL_LINES = 9 + 10 + 16 + 8;
	localparam int HOST_CYCLES = BUF_BYTES + 1 + 2 * BUF_BYTES * 3; // preload and two full reads
	localparam int WATCHDOG_CYCLES = TOTAL_LINES * (65 + 8 + 8) + HOST_CYCLES + 2000;

	logic                 clk;
	logic                 rst_n;
	logic                 psel;
	logic                 penable;
	logic                 pwrite;
	logic [7:0]           paddr;
	logic [31:0]          pwdata;
	logic [31:0]          prdata;
	logic                 pready;
	logic                 pslverr;
	logic                 dram_valid;
	logic                 dram_we;
	logic [31:0]          dram_addr;
	logic [LINE_BITS-1:0] dram_wdata;
	logic                 dram_ready;
	logic                 dram_rvalid;
	logic [LINE_BITS-1:0] dram_rdata;
	logic [BUF_AW-1:0]    host_addr;
	logic                 host_we;
	logic [7:0]           host_wdata;
	logic [7:0]           host_rdata;

	logic [7:0]           buf_img [BUF_BYTES]; // expected buffer contents
	logic [LINE_BITS-1:0] dram_img [logic [31:0]];
	logic [31:0]          exp_wr_addr [$];
	logic [LINE_BITS-1:0] exp_wr_line [$];
	logic [31:0]          exp_rd_addr [$];
	logic [31:0]          rng_stim;
	logic [31:0]          rng_dram;
	logic                 dram_allowed;
	int                   errors;
	int                   lines_written;
	int                   lines_read;

	// dram model state
	logic                 stall_prev;
	logic                 prev_we;
	logic [31:0]          prev_addr;
	logic [LINE_BITS-1:0] prev_wdata;
	logic                 rd_pending;
	logic [2:0]           rd_delay;
	logic [31:0]          rd_addr_q;

	fpu_dma_top u_fpu_dma_top (
		.clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
		.pslverr, .dram_valid, .dram_we, .dram_addr, .dram_wdata, .dram_ready,
		.dram_rvalid, .dram_rdata, .host_addr, .host_we, .host_wdata, .host_rdata
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [LINE_BITS-1:0] random_line();
		logic [LINE_BITS-1:0] line;
		for (int i = 0; i < LINE_BITS / 32; i++) begin
			rng_stim = xorshift(rng_stim);
			line[32*i +: 32] = rng_stim;
		end
		return line;
	endfunction

	// unwritten dram returns a pattern of its address
	function automatic logic [LINE_BITS-1:0] dram_line(input logic [31:0] a);
		if (dram_img.exists(a))
			return dram_img[a];
		return {16{a ^ 32'hc3a5_0f1e}};
	endfunction

	function automatic logic [LINE_BITS-1:0] build_line(input int base);
		logic [LINE_BITS-1:0] line;
		for (int k = 0; k < LINE_BYTES; k++)
			line[LINE_BITS-1-8*k -: 8] = buf_img[base + k]; // first byte on top
		return line;
	endfunction

	task automatic report_mismatch(input string name, input logic [LINE_BITS-1:0] exp,
			input logic [LINE_BITS-1:0] got);
		errors++;
		$display("error at %0t: %s expected %0h, got %0h", $time, name, exp, got);
	endtask

	task automatic report_failure(input string msg);
		errors++;
		$display("failure at %0t: %s", $time, msg);
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
		@(posedge clk);
		psel <= 1'b1;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);
		assert (pready) else report_mismatch("pready", 1'b1, pready);
		err = pslverr;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		@(posedge clk);
		psel <= 1'b1;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);
		assert (pready) else report_mismatch("pready", 1'b1, pready);
		data = prdata;
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic reg_check(input logic [7:0] addr, input logic [31:0] val,
			input logic [31:0] mask);
		logic        err;
		logic [31:0] rd;
		apb_write(addr, val, err);
		apb_read(addr, rd);
		assert (rd == (val & mask))
			else report_mismatch($sformatf("prdata[%02h]", addr), val & mask, rd);
	endtask

	task automatic host_write(input logic [BUF_AW-1:0] a, input logic [7:0] d);
		@(posedge clk);
		host_addr <= a;
		host_we <= 1'b1;
		host_wdata <= d;
	endtask

	task automatic host_read(input logic [BUF_AW-1:0] a, output logic [7:0] d);
		@(posedge clk);
		host_addr <= a;
		host_we <= 1'b0;
		@(posedge clk);
		@(posedge clk); // registered read
		d = host_rdata;
	endtask

	task automatic check_buffer();
		logic [7:0] d;
		for (int a = 0; a < BUF_BYTES; a++) begin
			host_read(12'(a), d);
			assert (d == buf_img[a])
				else report_mismatch($sformatf("host_rdata[%0d]", a), buf_img[a], d);
		end
	endtask

	task automatic wait_idle(output logic [31:0] st);
		do
			apb_read(REG_STATUS, st);
		while (st[0]);
	endtask

	task automatic queue_store(input logic [31:0] base, input int w, input int h,
			input logic [31:0] stride);
		for (int r = 0; r < h; r++) begin
			for (int l = 0; l < w / LINE_BYTES; l++) begin
				exp_wr_addr.push_back(base + 32'(r) * stride + 32'(l * LINE_BYTES));
				exp_wr_line.push_back(build_line(r * BUF_ROW_BYTES + l * LINE_BYTES));
			end
		end
	endtask

	// fills dram with random lines and predicts the buffer after the load
	task automatic queue_load(input logic [31:0] base, input int w, input int h,
			input logic [31:0] stride);
		logic [31:0]          a;
		logic [LINE_BITS-1:0] line;
		for (int r = 0; r < h; r++) begin
			for (int l = 0; l < w / LINE_BYTES; l++) begin
				a = base + 32'(r) * stride + 32'(l * LINE_BYTES);
				dram_img[a] = random_line();
				line = dram_line(a);
				exp_rd_addr.push_back(a);
				for (int k = 0; k < LINE_BYTES; k++)
					buf_img[r * BUF_ROW_BYTES + l * LINE_BYTES + k] = line[LINE_BITS-1-8*k -: 8];
			end
		end
	endtask

	task automatic run_xfer(input cmd_e c, input logic [31:0] wa, input logic [31:0] ra,
			input int w, input int h, input logic [31:0] stride, input logic poke_busy);
		logic        err;
		logic [31:0] st;
		logic [2:0]  exp_st;
		int          n_st;
		int          n_ld;
		int          wr_before;
		int          rd_before;
		n_st = (c == CMD_LOAD) ? 0 : h * w / LINE_BYTES;
		n_ld = (c == CMD_STORE) ? 0 : h * w / LINE_BYTES;
		exp_st = poke_busy ? 3'b110 : 3'b010;
		apb_write(REG_WR_ADDR, wa, err);
		apb_write(REG_RD_ADDR, ra, err);
		apb_write(REG_WIDTH, 32'(w), err);
		apb_write(REG_HEIGHT, 32'(h), err);
		apb_write(REG_STRIDE, stride, err);
		if (c != CMD_LOAD)
			queue_store(wa, w, h, stride);
		if (c != CMD_STORE)
			queue_load(ra, w, h, stride);
		wr_before = lines_written;
		rd_before = lines_read;
		dram_allowed = 1'b1;
		apb_write(REG_CTRL, {29'd0, c, 1'b1}, err);
		assert (!err) else report_failure("a valid start was refused");
		if (poke_busy) begin
			apb_write(REG_CTRL, {29'd0, CMD_LOAD, 1'b1}, err);
			assert (err) else report_failure("a start while busy was not refused");
		end
		wait_idle(st);
		dram_allowed = 1'b0;
		assert (st[2:0] == exp_st) else report_mismatch("status", exp_st, st[2:0]);
		assert (lines_written - wr_before == n_st)
			else report_mismatch("lines written", n_st, lines_written - wr_before);
		assert (lines_read - rd_before == n_ld)
			else report_mismatch("lines read", n_ld, lines_read - rd_before);
		assert (exp_wr_addr.size() == 0 && exp_rd_addr.size() == 0)
			else report_failure("command ended with dram lines still missing");
	endtask

	task automatic reject_geometry(input int w, input int h);
		logic        err;
		logic [31:0] st;
		apb_write(REG_WIDTH, 32'(w), err);
		apb_write(REG_HEIGHT, 32'(h), err);
		apb_write(REG_CTRL, {29'd0, CMD_STORE, 1'b1}, err);
		assert (err) else report_failure($sformatf("start with %0d x %0d not refused", w, h));
		apb_read(REG_STATUS, st);
		assert (st[2] && !st[0]) else report_mismatch("status err/busy", 2'b10, {st[2], st[0]});
		repeat (20) @(posedge clk); // nothing may reach dram
	endtask

	// dram line model with random back-pressure and read delay
	always @(posedge clk) begin
		rng_dram = xorshift(rng_dram);
		dram_ready <= (rng_dram[1:0] != 2'b00);
		dram_rvalid <= 1'b0;
		if (stall_prev) begin
			assert (dram_valid) else report_failure("dram_valid dropped before acceptance");
			assert (dram_we == prev_we) else report_mismatch("dram_we", prev_we, dram_we);
			assert (dram_addr == prev_addr)
				else report_mismatch("dram_addr", prev_addr, dram_addr);
			assert (dram_wdata == prev_wdata)
				else report_mismatch("dram_wdata", prev_wdata, dram_wdata);
		end
		if (rd_pending) begin
			if (rd_delay == 3'd0) begin
				dram_rvalid <= 1'b1;
				dram_rdata <= dram_line(rd_addr_q);
				rd_pending = 1'b0;
			end else begin
				rd_delay = rd_delay - 3'd1;
			end
		end
		if (dram_valid && dram_ready) begin
			if (dram_we) begin
				if (exp_wr_addr.size() == 0) begin
					report_failure("unexpected dram write");
				end else begin
					assert (dram_addr == exp_wr_addr[0])
						else report_mismatch("dram_addr", exp_wr_addr[0], dram_addr);
					assert (dram_wdata == exp_wr_line[0])
						else report_mismatch("dram_wdata", exp_wr_line[0], dram_wdata);
					void'(exp_wr_addr.pop_front());
					void'(exp_wr_line.pop_front());
				end
				dram_img[dram_addr] = dram_wdata;
				lines_written++;
			end else begin
				assert (exp_wr_addr.size() == 0)
					else report_failure("read before store finished");
				assert (!rd_pending) else report_failure("second read while one is outstanding");
				if (exp_rd_addr.size() == 0) begin
					report_failure("unexpected dram read");
				end else begin
					assert (dram_addr == exp_rd_addr[0])
						else report_mismatch("dram_addr", exp_rd_addr[0], dram_addr);
					void'(exp_rd_addr.pop_front());
				end
				rd_pending = 1'b1;
				rd_delay = rng_dram[6:4];
				rd_addr_q = dram_addr;
				lines_read++;
			end
		end
		stall_prev = dram_valid && !dram_ready;
		prev_we = dram_we;
		prev_addr = dram_addr;
		prev_wdata = dram_wdata;
	end

	a_no_stray_req: assert property (@(posedge clk) disable iff (!rst_n)
		dram_valid |-> dram_allowed)
		else report_failure("dram request outside an accepted command");

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		report_failure("watchdog expired before the tests finished");
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		logic [31:0] st;
		clk = 1'b0;
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		dram_ready = 1'b0;
		dram_rvalid = 1'b0;
		dram_rdata = '0;
		host_addr = '0;
		host_we = 1'b0;
		host_wdata = '0;
		rng_stim = {SEED[15:0], SEED[31:16]};
		rng_dram = SEED;
		dram_allowed = 1'b0;
		errors = 0;
		lines_written = 0;
		lines_read = 0;
		stall_prev = 1'b0;
		rd_pending = 1'b0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		apb_read(REG_STATUS, st);
		assert (st[2:0] == 3'b000) else report_mismatch("status", 3'b000, st[2:0]);
		assert (!dram_valid) else report_mismatch("dram_valid", 1'b0, dram_valid);
		reg_check(REG_WR_ADDR, 32'h1234_5670, 32'hffff_ffff);
		reg_check(REG_RD_ADDR, 32'h8765_4320, 32'hffff_ffff);
		reg_check(REG_WIDTH, 32'h0000_02a5, 32'h0000_03ff);
		reg_check(REG_HEIGHT, 32'h0000_000b, 32'h0000_000f);
		reg_check(REG_STRIDE, 32'hdead_beef, 32'hffff_ffff);

		for (int a = 0; a < BUF_BYTES; a++) begin
			rng_stim = xorshift(rng_stim);
			buf_img[a] = rng_stim[7:0];
			host_write(12'(a), rng_stim[7:0]);
		end
		@(posedge clk);
		host_we <= 1'b0;

		run_xfer(CMD_STORE, 32'h1000_0000, 32'h0, 192, 3, 32'h400, 1'b0);
		reject_geometry(100, 2);
		reject_geometry(64, 0);
		reject_geometry(576, 1);
		run_xfer(CMD_LOAD, 32'h0, 32'h2000_0000, 128, 5, 32'h1000, 1'b0);
		check_buffer();
		run_xfer(CMD_STORE_LOAD, 32'h3000_0000, 32'h4000_0000, 256, 2, 32'h200, 1'b0);
		check_buffer();
		run_xfer(CMD_STORE, 32'h5000_0000, 32'h0, 64, 8, 32'h40, 1'b1);

		$display("lines written %0d, lines read %0d, errors %0d",
			lines_written, lines_read, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
source/fpu_mem_pkg.sv
source/fpu_ctrl_pkg.sv
source/fpu_apb_regs.sv
source/fpu_req_controller.sv
source/line_packer.sv
source/line_unpacker.sv
source/fpu_line_buffer.sv
source/fpu_dma_top.sv
tb/tb_fpu_dma.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_fpu_dma
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only when the testbench prints the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
